//--- files.f
+incdir+include
src/mul_pkg.sv
src/key_if.sv
src/key_debounce.sv
src/mul_control.sv
src/mul_pipe.sv
src/disp_format.sv
src/seg_scan.sv
src/led_flow.sv
src/mul_top.sv
testbench/mul_checker.sv
testbench/tb_mul_top.sv

//--- include/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand and product widths
`define MUL_W       8
`define PROD_W      16

// key count and debounce depth
`define KEY_N       5
`define DEB_CYCLES  4

// led walk rate, 50 cycles is half a second at 100 Hz
`define FLOW_STEP   50

// display
`define DIGIT_N     6
`define DIG_BLANK   5'd16
`define DIG_DASH    5'd17

`endif

//--- src/disp_format.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module disp_format (
    input  mul_pkg::mode_t        mode,
    input  logic [`MUL_W-1:0]     op_x,
    input  logic [`MUL_W-1:0]     op_y,
    input  logic                  fmt_dec,
    input  logic [`PROD_W-1:0]    product,
    output mul_pkg::digit_word_t  digits
);

    import mul_pkg::*;

    localparam digit_t BLK  = `DIG_BLANK;
    localparam digit_t DASH = `DIG_DASH;

    digit_t [2:0] x_dec;    // [2] is hundreds
    digit_t [2:0] y_dec;
    digit_t [4:0] p_dec;    // [4] is ten-thousands

    // decimal digit at position pos, pos up to 4
    function automatic digit_t dec_digit(input logic [`PROD_W-1:0] v, input int pos);
        logic [`PROD_W-1:0] t;
        t = v;
        for (int i = 0; i < 4; i++) begin
            if (i < pos) begin
                t = t / 10;
            end
        end
        return digit_t'(t % 10);
    endfunction

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            x_dec[i] = dec_digit(16'(op_x), i);
            y_dec[i] = dec_digit(16'(op_y), i);
        end
        for (int i = 0; i < 5; i++) begin
            p_dec[i] = dec_digit(product, i);
        end
    end

    always_comb begin
        case (mode)
            ST_INPUT: begin
                if (fmt_dec) begin
                    digits = {x_dec, y_dec};
                end else begin
                    digits = {BLK, digit_t'(op_x[7:4]), digit_t'(op_x[3:0]),
                              BLK, digit_t'(op_y[7:4]), digit_t'(op_y[3:0])};
                end
            end
            ST_ANSWER: begin
                if (fmt_dec) begin
                    digits = {BLK, p_dec};
                end else begin
                    digits = {BLK, BLK,
                              digit_t'(product[15:12]), digit_t'(product[11:8]),
                              digit_t'(product[7:4]), digit_t'(product[3:0])};
                end
            end
            default: begin
                digits = {`DIGIT_N{DASH}};     // flow state
            end
        endcase
    end

endmodule

//--- src/key_debounce.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module key_debounce (
    input  logic              clk_100hz,
    input  logic              rst_,
    input  logic [`KEY_N-1:0] key,      // active low
    key_if.src                ev
);

    localparam int CW = (`DEB_CYCLES > 1) ? $clog2(`DEB_CYCLES) : 1;

    logic [`KEY_N-1:0] sync_a;
    logic [`KEY_N-1:0] sync_b;
    logic [`KEY_N-1:0] stable;          // debounced level, 1 = released
    logic [`KEY_N-1:0] press;
    logic [CW-1:0]     cnt [`KEY_N];    // consecutive samples differing from stable

    always_ff @(posedge clk_100hz or negedge rst_) begin
        if (!rst_) begin
            sync_a <= '1;
            sync_b <= '1;
            stable <= '1;
            press  <= '0;
            for (int i = 0; i < `KEY_N; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            sync_a <= key;
            sync_b <= sync_a;
            press  <= '0;
            for (int i = 0; i < `KEY_N; i++) begin
                if (sync_b[i] != stable[i]) begin
                    if (cnt[i] == CW'(`DEB_CYCLES - 1)) begin
                        stable[i] <= sync_b[i];
                        cnt[i]    <= '0;
                        press[i]  <= ~sync_b[i];    // only the falling side counts
                    end else begin
                        cnt[i] <= cnt[i] + 1'b1;
                    end
                end else begin
                    cnt[i] <= '0;   // bounce, start over
                end
            end
        end
    end

    assign ev.ev_mode  = press[0];
    assign ev.ev_inc_x = press[1];
    assign ev.ev_inc_y = press[2];
    assign ev.ev_ans   = press[3];
    assign ev.ev_fmt   = press[4];

endmodule

//--- src/key_if.sv
`timescale 1ns/1ps

interface key_if;

    logic ev_mode;      // key 0
    logic ev_inc_x;     // key 1
    logic ev_inc_y;     // key 2
    logic ev_ans;       // key 3
    logic ev_fmt;       // key 4

    // one-cycle press strobes, never refused
    modport src (
        output ev_mode, ev_inc_x, ev_inc_y, ev_ans, ev_fmt
    );

    modport dst (
        input ev_mode, ev_inc_x, ev_inc_y, ev_ans, ev_fmt
    );

endinterface

//--- src/led_flow.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module led_flow (
    input  logic            clk_100hz,
    input  logic            rst_,
    input  mul_pkg::mode_t  mode,
    output logic [7:0]      led     // active low
);

    import mul_pkg::*;

    localparam int TW = $clog2(`FLOW_STEP);

    logic [TW-1:0] tick;
    logic [2:0]    pos;     // 0 means bit 7 lit

    always_ff @(posedge clk_100hz or negedge rst_) begin
        if (!rst_) begin
            tick <= '0;
            pos  <= '0;
        end else if (mode != ST_FLOW) begin
            tick <= '0;     // restart from bit 7 on return
            pos  <= '0;
        end else if (tick == TW'(`FLOW_STEP - 1)) begin
            tick <= '0;
            pos  <= pos + 1'b1;
        end else begin
            tick <= tick + 1'b1;
        end
    end

    assign led = (mode == ST_FLOW) ? ~(8'h80 >> pos) : 8'hff;

endmodule

//--- src/mul_control.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_control (
    input  logic               clk_100hz,
    input  logic               rst_,
    key_if.dst                 ev,
    output mul_pkg::mode_t     mode,
    output logic [`MUL_W-1:0]  op_x,
    output logic [`MUL_W-1:0]  op_y,
    output logic               fmt_dec     // 0 hex, 1 decimal
);

    import mul_pkg::*;

    mode_t mode_nxt;

    // mode key wins over ans key
    always_comb begin
        mode_nxt = mode;
        case (mode)
            ST_FLOW: begin
                if (ev.ev_mode) begin
                    mode_nxt = ST_INPUT;
                end
            end
            ST_INPUT: begin
                if (ev.ev_mode) begin
                    mode_nxt = ST_FLOW;
                end else if (ev.ev_ans) begin
                    mode_nxt = ST_ANSWER;
                end
            end
            ST_ANSWER: begin
                if (ev.ev_mode) begin
                    mode_nxt = ST_FLOW;
                end else if (ev.ev_ans) begin
                    mode_nxt = ST_INPUT;
                end
            end
            default: begin
                mode_nxt = ST_FLOW;
            end
        endcase
    end

    always_ff @(posedge clk_100hz or negedge rst_) begin
        if (!rst_) begin
            mode <= ST_FLOW;
        end else begin
            mode <= mode_nxt;
        end
    end

    // operands only move while entering them
    always_ff @(posedge clk_100hz or negedge rst_) begin
        if (!rst_) begin
            op_x <= '0;
            op_y <= '0;
        end else if (mode == ST_INPUT) begin
            if (ev.ev_inc_x) begin
                op_x <= op_x + 1'b1;    // wraps at 255
            end
            if (ev.ev_inc_y) begin
                op_y <= op_y + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100hz or negedge rst_) begin
        if (!rst_) begin
            fmt_dec <= 1'b0;
        end else if (ev.ev_fmt && mode != ST_FLOW) begin
            fmt_dec <= ~fmt_dec;
        end
    end

endmodule

//--- src/mul_pipe.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_pipe (
    input  logic                clk_100hz,
    input  logic                rst_,
    input  logic [`MUL_W-1:0]   op_x,
    input  logic [`MUL_W-1:0]   op_y,
    output logic [`PROD_W-1:0]  product
);

    localparam int H = `MUL_W / 2;

    // partial products, lo/hi halves of x then y
    logic [`MUL_W-1:0] pp_ll;
    logic [`MUL_W-1:0] pp_lh;
    logic [`MUL_W-1:0] pp_hl;
    logic [`MUL_W-1:0] pp_hh;

    // stage one
    always_ff @(posedge clk_100hz or negedge rst_) begin
        if (!rst_) begin
            pp_ll <= '0;
            pp_lh <= '0;
            pp_hl <= '0;
            pp_hh <= '0;
        end else begin
            pp_ll <= op_x[H-1:0]      * op_y[H-1:0];
            pp_lh <= op_x[H-1:0]      * op_y[`MUL_W-1:H];
            pp_hl <= op_x[`MUL_W-1:H] * op_y[H-1:0];
            pp_hh <= op_x[`MUL_W-1:H] * op_y[`MUL_W-1:H];
        end
    end

    // stage two, shifted sum
    always_ff @(posedge clk_100hz or negedge rst_) begin
        if (!rst_) begin
            product <= '0;
        end else begin
            product <= (16'(pp_hh) << `MUL_W) + (16'(pp_lh) << H)
                     + (16'(pp_hl) << H) + 16'(pp_ll);
        end
    end

endmodule

//--- src/mul_pkg.sv
`include "mul_defines.svh"

package mul_pkg;

    // controller modes
    typedef enum logic [1:0] {
        ST_FLOW   = 2'd0,   // walking led, dashes on display
        ST_INPUT  = 2'd1,   // operand entry
        ST_ANSWER = 2'd2    // product shown
    } mode_t;

    // 0..15 hex value, 16 blank, 17 dash
    typedef logic [4:0] digit_t;

    // index 5 is the leftmost digit
    typedef digit_t [`DIGIT_N-1:0] digit_word_t;

endpackage

//--- src/mul_top.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_top (
    input  logic                clk_100hz,
    input  logic                rst_,
    input  logic [`KEY_N-1:0]   key,
    output logic [7:0]          seg_data,
    output logic [`DIGIT_N-1:0] seg_cs,
    output logic [7:0]          led
);

    import mul_pkg::*;

    mode_t               mode;
    logic [`MUL_W-1:0]   op_x;
    logic [`MUL_W-1:0]   op_y;
    logic                fmt_dec;
    logic [`PROD_W-1:0]  product;
    digit_word_t         digits;

    key_if kev ();

    key_debounce u_deb (
        .clk_100hz (clk_100hz),
        .rst_      (rst_),
        .key       (key),
        .ev        (kev.src)
    );

    mul_control u_ctrl (
        .clk_100hz (clk_100hz),
        .rst_      (rst_),
        .ev        (kev.dst),
        .mode      (mode),
        .op_x      (op_x),
        .op_y      (op_y),
        .fmt_dec   (fmt_dec)
    );

    mul_pipe u_mul (
        .clk_100hz (clk_100hz),
        .rst_      (rst_),
        .op_x      (op_x),
        .op_y      (op_y),
        .product   (product)
    );

    disp_format u_fmt (
        .mode      (mode),
        .op_x      (op_x),
        .op_y      (op_y),
        .fmt_dec   (fmt_dec),
        .product   (product),
        .digits    (digits)
    );

    seg_scan u_scan (
        .clk_100hz (clk_100hz),
        .rst_      (rst_),
        .digits    (digits),
        .seg_data  (seg_data),
        .seg_cs    (seg_cs)
    );

    led_flow u_led (
        .clk_100hz (clk_100hz),
        .rst_      (rst_),
        .mode      (mode),
        .led       (led)
    );

endmodule

//--- src/seg_scan.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module seg_scan (
    input  logic                  clk_100hz,
    input  logic                  rst_,
    input  mul_pkg::digit_word_t  digits,
    output logic [7:0]            seg_data,   // active low, bit 7 dp
    output logic [`DIGIT_N-1:0]   seg_cs      // active low
);

    import mul_pkg::*;

    localparam logic [2:0] LAST = 3'(`DIGIT_N - 1);

    logic [2:0] idx;
    logic [2:0] idx_nxt;

    // lit segments, bit 0 = a .. bit 6 = g
    function automatic logic [6:0] seg_lit(input digit_t d);
        case (d)
            5'd0:       return 7'h3f;
            5'd1:       return 7'h06;
            5'd2:       return 7'h5b;
            5'd3:       return 7'h4f;
            5'd4:       return 7'h66;
            5'd5:       return 7'h6d;
            5'd6:       return 7'h7d;
            5'd7:       return 7'h07;
            5'd8:       return 7'h7f;
            5'd9:       return 7'h6f;
            5'd10:      return 7'h77;
            5'd11:      return 7'h7c;
            5'd12:      return 7'h39;
            5'd13:      return 7'h5e;
            5'd14:      return 7'h79;
            5'd15:      return 7'h71;
            `DIG_DASH:  return 7'h40;
            default:    return 7'h00;   // blank
        endcase
    endfunction

    assign idx_nxt = (idx == 3'd0) ? LAST : idx - 1'b1;

    always_ff @(posedge clk_100hz or negedge rst_) begin
        if (!rst_) begin
            idx      <= 3'd0;   // first edge lands on the leftmost digit
            seg_cs   <= '1;
            seg_data <= 8'hff;
        end else begin
            idx      <= idx_nxt;
            seg_cs   <= ~(`DIGIT_N'(1) << idx_nxt);
            seg_data <= {1'b1, ~seg_lit(digits[idx_nxt])};
        end
    end

endmodule

//--- testbench/mul_checker.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_checker (
    input logic                clk_100hz,
    input logic                rst_,
    input logic [`DIGIT_N-1:0] seg_cs,
    input logic [7:0]          led,
    input mul_pkg::mode_t      mode,
    input logic [`KEY_N-1:0]   strb     // key_if strobes with mode on bit 0
);

    import mul_pkg::*;

    int fail_cnt = 0;   // failed assertion count

    a_seg_cs: assert property (@(posedge clk_100hz) disable iff (!rst_)
        $onehot(~seg_cs) || seg_cs == '1)
        else begin
            fail_cnt++;
            $error("seg_cs selects more than one digit: %b", seg_cs);
        end

    a_led: assert property (@(posedge clk_100hz) disable iff (!rst_)
        ($onehot(~led) || led == 8'hff) && (mode == ST_FLOW || led == 8'hff))
        else begin
            fail_cnt++;
            $error("led %b not valid in mode %s", led, mode.name());
        end

    // one pulse per press
    a_strobe: assert property (@(posedge clk_100hz) disable iff (!rst_)
        (strb & $past(strb)) == '0)
        else begin
            fail_cnt++;
            $error("key strobe high for two cycles: %b", strb);
        end

    a_no_skip: assert property (@(posedge clk_100hz) disable iff (!rst_)
        mode == ST_FLOW |=> mode != ST_ANSWER)
        else begin
            fail_cnt++;
            $error("mode went from flow straight to answer");
        end

endmodule

bind mul_top mul_checker u_chk (
    .clk_100hz (clk_100hz),
    .rst_      (rst_),
    .seg_cs    (seg_cs),
    .led       (led),
    .mode      (mode),
    .strb      ({kev.ev_fmt, kev.ev_ans, kev.ev_inc_y, kev.ev_inc_x, kev.ev_mode})
);

//--- testbench/tb_mul_top.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module tb_mul_top;

    import mul_pkg::*;

    localparam int ROWS = 17;
    localparam int NONE = 7;    // row without a key press
    localparam int RND  = -1;
    localparam int FILL = -2;   // press until the operand reads 255

    // lit segments for codes 0..17 with bit 0 = a
    localparam logic [6:0] SEG_TAB [18] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d,
        7'h7d, 7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71, 7'h00, 7'h40};

    // key 0 mode, 1 inc_x, 2 inc_y, 3 ans, 4 fmt; check 0 none, 1 display, 2 led walk
    int tab_key [ROWS] = '{NONE, 1, 0, 1, 2, 3, 2, 3, 1, 1, 1, 2, 4, 3, 4, 0, NONE};
    int tab_cnt [ROWS] = '{0, 1, 1, RND, RND, 1, 2, 1, FILL, 1, FILL, FILL, 1, 1, 1, 1, 0};
    int tab_chk [ROWS] = '{2, 1, 1, 0, 1, 1, 0, 1, 1, 1, 0, 1, 1, 1, 1, 1, 2};

    logic         clk_100hz = 1'b0;
    logic         rst_;
    logic         rst_drv;
    logic [4:0]   key;
    logic [4:0]   key_drv;
    logic [7:0]   seg_data;
    logic [5:0]   seg_cs;
    logic [7:0]   led;
    logic [7:0]   led_last;
    mode_t        m_mode;
    int           m_x;
    int           m_y;
    bit           m_dec;
    int           led_age;
    int           prev_run;     // cycles the previous led value lasted
    int           cycles;
    int           limit;
    int           n;
    int           row_err;
    int           errors;
    int           rows_bad;
    int           assert_fails;

    mul_top UUT (
        .clk_100hz (clk_100hz),
        .rst_      (rst_),
        .key       (key),
        .seg_data  (seg_data),
        .seg_cs    (seg_cs),
        .led       (led)
    );

    always #50 clk_100hz = ~clk_100hz;

    always @(posedge clk_100hz) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // drive after the rising edge, sample on the falling edge
    task automatic step_cycle();
        @(posedge clk_100hz);
        #5;
        key  = key_drv;
        rst_ = rst_drv;
        @(negedge clk_100hz);
        if (!rst_) begin
            led_age = 0;
        end else if (led !== led_last) begin
            prev_run = led_age;
            led_age  = 1;
        end else begin
            led_age++;
        end
        led_last = led;
    endtask

    task automatic apply_event(input int k);
        case (k)
            0: m_mode = (m_mode == ST_FLOW) ? ST_INPUT : ST_FLOW;
            1: m_x = (m_mode == ST_INPUT) ? (m_x + 1) % 256 : m_x;
            2: m_y = (m_mode == ST_INPUT) ? (m_y + 1) % 256 : m_y;
            3: m_mode = (m_mode == ST_INPUT) ? ST_ANSWER
                      : (m_mode == ST_ANSWER) ? ST_INPUT : m_mode;
            4: m_dec = (m_mode != ST_FLOW) ? !m_dec : m_dec;
            default: ;
        endcase
    endtask

    task automatic press_key(input int k);
        key_drv[k] = 1'b0;
        repeat (8) step_cycle();
        key_drv[k] = 1'b1;
        repeat (8) step_cycle();
        apply_event(k);
    endtask

    function automatic logic [29:0] expected_word();
        int          d [5:0];   // d[5] leftmost
        int          p;
        logic [29:0] w;
        p = m_x * m_y;
        if (m_mode == ST_FLOW) begin
            d = '{17, 17, 17, 17, 17, 17};
        end else if (m_mode == ST_INPUT && !m_dec) begin
            d = '{16, m_x / 16, m_x % 16, 16, m_y / 16, m_y % 16};
        end else if (m_mode == ST_INPUT) begin
            d = '{m_x / 100, m_x / 10 % 10, m_x % 10, m_y / 100, m_y / 10 % 10, m_y % 10};
        end else if (!m_dec) begin
            d = '{16, 16, p / 4096, p / 256 % 16, p / 16 % 16, p % 16};
        end else begin
            d = '{16, p / 10000, p / 1000 % 10, p / 100 % 10, p / 10 % 10, p % 10};
        end
        for (int i = 0; i < 6; i++) begin
            w[5*i +: 5] = 5'(d[i]);
        end
        return w;
    endfunction

    function automatic logic [4:0] decode_seg(input logic [7:0] s);
        for (int c = 0; c < 18; c++) begin
            if (s == {1'b1, ~SEG_TAB[c]}) begin
                return 5'(c);
            end
        end
        return 5'd31;   // no such pattern
    endfunction

    task automatic compare_display();
        logic [29:0] got;
        logic [29:0] exp;
        logic [5:0]  seen;
        got  = '1;
        seen = '0;
        exp  = expected_word();
        repeat (4) step_cycle();    // product latency
        for (int c = 0; c < 6; c++) begin
            step_cycle();
            for (int i = 0; i < 6; i++) begin
                if (seg_cs == ~(6'd1 << i)) begin
                    got[5*i +: 5] = decode_seg(seg_data);
                    seen[i] = 1'b1;
                end
            end
        end
        if (seen != 6'h3f) begin
            $display("scan missed digits at %0t, visited %b", $time, seen);
            row_err++;
        end else if (got !== exp) begin
            $display("FAIL %0t digits expected %h got %h", $time, exp, got);
            row_err++;
        end
        if (m_mode != ST_FLOW && led !== 8'hff) begin
            $display("FAIL %0t led expected ff got %h", $time, led);
            row_err++;
        end
    endtask

    task automatic verify_led_walk();
        int wait_n;
        wait_n = 0;
        if (led !== 8'h7f) begin
            $display("FAIL %0t led expected 7f got %h", $time, led);
            row_err++;
        end
        while (led === 8'h7f && wait_n < `FLOW_STEP + 10) begin
            step_cycle();
            wait_n++;
        end
        if (led !== 8'hbf) begin
            $display("FAIL %0t led expected bf got %h", $time, led);
            row_err++;
        end else if (prev_run < `FLOW_STEP - 2 || prev_run > `FLOW_STEP + 2) begin
            $display("led stepped after %0d cycles instead of about %0d", prev_run, `FLOW_STEP);
            row_err++;
        end
    endtask

    initial begin
        void'($urandom(32'he98c));
        key = '1;
        key_drv = '1;
        rst_ = 1'b0;
        rst_drv = 1'b0;
        m_mode = ST_FLOW;
        m_x = 0;
        m_y = 0;
        m_dec = 1'b0;
        led_last = 8'hff;
        cycles = 0;
        errors = 0;
        rows_bad = 0;
        limit = 200;
        for (int r = 0; r < ROWS; r++) begin
            if (tab_cnt[r] == RND) begin
                tab_cnt[r] = $urandom_range(12, 1);
            end
            n = (tab_cnt[r] == FILL) ? 255 : tab_cnt[r];
            limit += n * 16 + ((tab_chk[r] == 2) ? `FLOW_STEP + 10 : 10);
        end
        repeat (3) step_cycle();
        rst_drv = 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            row_err = 0;
            n = tab_cnt[r];
            if (n == FILL) begin
                n = 255 - ((tab_key[r] == 1) ? m_x : m_y);
            end
            repeat (n) press_key(tab_key[r]);
            if (tab_chk[r] == 1) begin
                compare_display();
            end else if (tab_chk[r] == 2) begin
                verify_led_walk();
            end
            $display("row %0d key %0d presses %0d: %s", r, tab_key[r], n,
                     (row_err == 0) ? "ok" : "mismatch");
            errors += row_err;
            rows_bad += (row_err != 0);
        end
        assert_fails = UUT.u_chk.fail_cnt;
        $display("rows %0d, bad rows %0d, errors %0d, assertion failures %0d",
                 ROWS, rows_bad, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
